//--- common/m92_defines.svh
// M92 memory map constants
`ifndef M92_DEFINES_SVH
`define M92_DEFINES_SVH

// CPU address windows
`define M92_ROM_END       20'hBFFFF
`define M92_BANK_WIN_LO   20'hC0000
`define M92_BANK_WIN_HI   20'hCFFFF
`define M92_RAM_WIN       20'hE0000
`define M92_RAM_SIZE      20'h10000
`define M92_VIDCTRL_ADDR  20'hF9800

// SDRAM region bases
`define M92_BANK_BASE     25'h100000
`define M92_RAM_BASE      25'h200000

// CPU I/O ports
`define M92_IO_SW         8'h00
`define M92_IO_FLAGS      8'h02
`define M92_IO_DIP        8'h04
`define M92_IO_DBG        8'h06
`define M92_IO_BANK       8'h20

`endif

//--- common/m92_pkg.sv
// M92 memory subsystem types
`default_nettype none

package m92_pkg;

    // ==============================
    // Board configuration
    // ==============================
    typedef struct packed {
        logic bank_enable;      // Banked ROM window present
        logic ram_wide;         // 64 KiB work RAM instead of 16 KiB
    } board_cfg_t;

    // ==============================
    // CPU memory bus cycle
    // ==============================
    typedef struct packed {
        logic [19:0] addr;      // Byte address
        logic [15:0] dout;      // Write data from the CPU
        logic [1:0]  be;        // Byte enables, bit 0 is the low byte
        logic        rd;        // One-cycle read strobe
        logic        wr;        // One-cycle write strobe
    } cpu_bus_t;

    // One-hot address region
    typedef struct packed {
        logic ram_rom;
        logic banked;
        logic vid_ctrl;
        logic none;
    } region_t;

    // ==============================
    // SDRAM request
    // ==============================
    typedef struct packed {
        logic [24:0] addr;      // Word aligned SDRAM address
        logic [15:0] din;
        logic [1:0]  wr_sel;    // Zero means read
    } sdr_req_t;

endpackage

`default_nettype wire

//--- cpu_bridge/m92_cpu_bridge.sv
// CPU to SDRAM bridge
`timescale 1ns/1ps
`default_nettype none

module m92_cpu_bridge import m92_pkg::*; (
    input  wire logic        CLK_32M,
    input  wire logic        reset_n,
    input  cpu_bus_t         cpu_bus,
    input  region_t          region,
    input  wire logic [24:0] sdr_addr,
    input  wire logic        writable,
    input  wire logic        cpu_rdy,
    input  wire logic [15:0] cpu_rdata_mem,
    input  wire logic [15:0] vid_ctrl,
    output logic             cpu_req,
    output sdr_req_t         cpu_sdr,
    output logic [15:0]      cpu_rdata,
    output logic             cpu_busy,
    output logic             ce_cpu,
    output logic             vid_wr,
    output logic [15:0]      vid_data
);

    logic        rd_lat;
    logic        wr_lat;
    logic        rd_edge;
    logic        wr_edge;
    logic        sdr_region;
    logic        issue;
    logic        stall;
    logic [1:0]  ce_count;
    logic [15:0] word_out;
    logic [1:0]  word_sel;
    logic [15:0] rdata_q;
    logic [15:0] rdata_word;

    // Odd byte reads come back in the low lane
    function automatic logic [15:0] word_shuffle(input logic a0, input logic [15:0] data);
        word_shuffle = a0 ? {8'h00, data[15:8]} : data;
    endfunction

    // Strobes last one cycle on the bus, the latch stretches them to two
    assign rd_edge    = cpu_bus.rd & ~rd_lat;
    assign wr_edge    = cpu_bus.wr & ~wr_lat;
    assign sdr_region = region.ram_rom | region.banked;
    assign issue      = ~cpu_busy & sdr_region & (rd_edge | wr_edge);
    assign stall      = cpu_busy | (sdr_region & (cpu_bus.rd | rd_lat | cpu_bus.wr | wr_lat));

    assign word_out = cpu_bus.addr[0] ? {cpu_bus.dout[7:0], 8'h00} : cpu_bus.dout;
    assign word_sel = cpu_bus.addr[0] ? {cpu_bus.be[0], 1'b0} : cpu_bus.be;

    assign vid_wr   = wr_edge & region.vid_ctrl;
    assign vid_data = word_out;

    // ==============================
    // Request and clock enable
    // ==============================
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            rd_lat   <= 1'b0;
            wr_lat   <= 1'b0;
            cpu_req  <= 1'b0;
            cpu_busy <= 1'b0;
            ce_count <= 2'd0;
            ce_cpu   <= 1'b0;
        end else begin
            rd_lat  <= cpu_bus.rd;
            wr_lat  <= cpu_bus.wr;
            cpu_req <= issue;
            if (issue) cpu_busy <= 1'b1;
            else if (cpu_busy && cpu_rdy) cpu_busy <= 1'b0;

            ce_cpu <= 1'b0;
            if (!stall) begin                   // CPU waits on SDRAM
                ce_count <= ce_count + 2'd1;
                ce_cpu   <= &ce_count;
            end
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (issue) begin
            cpu_sdr.addr   <= sdr_addr;
            cpu_sdr.din    <= word_out;
            cpu_sdr.wr_sel <= (wr_edge && writable) ? word_sel : 2'b00;  // ROM writes become reads
        end
        if (cpu_busy && cpu_rdy) rdata_q <= cpu_rdata_mem;
    end

    // ==============================
    // Read data return
    // ==============================
    always_comb begin
        if (region.vid_ctrl) rdata_word = vid_ctrl;
        else if (region.none) rdata_word = 16'hffff;
        else rdata_word = rdata_q;
        cpu_rdata = word_shuffle(cpu_bus.addr[0], rdata_word);
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/m92_pkg.sv
src/address_translator.sv
src/m92_io_regs.sv
cpu_bridge/m92_cpu_bridge.sv
sdram_arb/sdr_port_latch.sv
sdram_arb/sdr_arbiter.sv
src/m92_mem_top.sv
tests/m92_mem_sva.sv
tests/tb_m92_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_m92_mem -f flist.f -o tb_m92_mem_sim

./obj_dir/tb_m92_mem_sim 2>&1 | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

//--- sdram_arb/sdr_arbiter.sv
// Fixed priority SDRAM arbiter
`timescale 1ns/1ps
`default_nettype none

module sdr_arbiter import m92_pkg::*; (
    input  wire logic        CLK_32M,
    input  wire logic        reset_n,
    input  wire logic        cpu_req,
    input  sdr_req_t         cpu_sdr,
    input  wire logic        sprite_req,
    input  wire logic [24:0] sprite_addr,
    input  wire logic        bg_req,
    input  wire logic [24:0] bg_addr,
    input  wire logic        mem_rdy,
    input  wire logic [63:0] mem_dout,
    output logic             cpu_rdy,
    output logic [15:0]      cpu_rdata_mem,
    output logic             sprite_rdy,
    output logic [63:0]      sprite_data,
    output logic             bg_rdy,
    output logic [31:0]      bg_data,
    output logic             mem_req,
    output logic [24:0]      mem_addr,
    output logic [15:0]      mem_din,
    output logic [1:0]       mem_wr_sel
);

    sdr_req_t   sprite_in;
    sdr_req_t   bg_in;
    sdr_req_t   sprite_info;
    sdr_req_t   bg_info;
    sdr_req_t   cpu_info;
    sdr_req_t   sel_info;
    logic [2:0] pending;                        // {cpu, bg, sprite}
    logic [2:0] grant;
    logic [2:0] done;
    logic [2:0] owner;
    logic       busy;

    // Video fetches are always reads
    assign sprite_in = '{addr: sprite_addr, din: 16'h0000, wr_sel: 2'b00};
    assign bg_in     = '{addr: bg_addr, din: 16'h0000, wr_sel: 2'b00};

    // ==============================
    // Port latches
    // ==============================
    sdr_port_latch #(.payload_t(logic [63:0])) sprite_port (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .req(sprite_req), .req_info(sprite_in), .grant(grant[0]), .done(done[0]),
        .mem_data(mem_dout),
        .pending(pending[0]), .info(sprite_info), .rdy(sprite_rdy), .data(sprite_data)
    );

    sdr_port_latch #(.payload_t(logic [31:0])) bg_port (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .req(bg_req), .req_info(bg_in), .grant(grant[1]), .done(done[1]),
        .mem_data(mem_dout[31:0]),
        .pending(pending[1]), .info(bg_info), .rdy(bg_rdy), .data(bg_data)
    );

    sdr_port_latch #(.payload_t(logic [15:0])) cpu_port (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .req(cpu_req), .req_info(cpu_sdr), .grant(grant[2]), .done(done[2]),
        .mem_data(mem_dout[15:0]),
        .pending(pending[2]), .info(cpu_info), .rdy(cpu_rdy), .data(cpu_rdata_mem)
    );

    // ==============================
    // Grant and ownership
    // ==============================
    assign grant[0] = ~busy & pending[0];
    assign grant[1] = ~busy & pending[1] & ~pending[0];
    assign grant[2] = ~busy & pending[2] & ~pending[1] & ~pending[0];
    assign done     = {3{mem_rdy & busy}} & owner;   // Only the owner sees the answer

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            owner <= 3'b000;
        end else if (|grant) begin
            busy  <= 1'b1;
            owner <= grant;
        end else if (busy && mem_rdy) begin
            busy  <= 1'b0;
        end
    end

    always_comb begin
        if (grant[0]) sel_info = sprite_info;
        else if (grant[1]) sel_info = bg_info;
        else sel_info = cpu_info;
    end

    assign mem_req    = |grant;
    assign mem_addr   = sel_info.addr;
    assign mem_din    = sel_info.din;
    assign mem_wr_sel = sel_info.wr_sel;

endmodule

`default_nettype wire

//--- sdram_arb/sdr_port_latch.sv
// SDRAM port request holder
`timescale 1ns/1ps
`default_nettype none

module sdr_port_latch import m92_pkg::*; #(
    parameter type payload_t = logic [15:0]
) (
    input  wire logic CLK_32M,
    input  wire logic reset_n,
    input  wire logic req,
    input  sdr_req_t  req_info,
    input  wire logic grant,
    input  wire logic done,
    input  payload_t  mem_data,
    output logic      pending,
    output sdr_req_t  info,
    output logic      rdy,
    output payload_t  data
);

    // Pending from the req pulse until the arbiter takes it
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            pending <= 1'b0;
            rdy     <= 1'b0;
        end else begin
            if (req) pending <= 1'b1;
            else if (grant) pending <= 1'b0;
            rdy <= done;                        // One cycle after mem_rdy
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (req) info <= req_info;
        if (done) data <= mem_data;
    end

endmodule

`default_nettype wire

//--- src/address_translator.sv
// CPU address decoder
`timescale 1ns/1ps
`default_nettype none
`include "m92_defines.svh"

module address_translator import m92_pkg::*; (
    input  wire logic [19:0] addr,
    input  board_cfg_t       board_cfg,
    input  wire logic [3:0]  bank_select,
    output region_t          region,
    output logic [24:0]      sdr_addr,
    output logic             writable
);

    logic [19:0] word_addr;
    logic [15:0] ram_off;
    logic        in_rom;
    logic        in_bank;
    logic        in_ram;

    assign word_addr = {addr[19:1], 1'b0};       // SDRAM is word addressed

    assign in_rom  = (addr <= `M92_ROM_END);
    assign in_bank = (addr >= `M92_BANK_WIN_LO) && (addr <= `M92_BANK_WIN_HI);
    assign in_ram  = (addr >= `M92_RAM_WIN) && (addr < (`M92_RAM_WIN + `M92_RAM_SIZE));

    // Small RAM boards mirror 16 KiB across the window
    assign ram_off = board_cfg.ram_wide ? word_addr[15:0] : {2'b00, word_addr[13:0]};

    // ==============================
    // Region and SDRAM address
    // ==============================
    always_comb begin
        region   = '0;
        sdr_addr = '0;
        writable = 1'b0;

        if (in_rom) begin
            region.ram_rom = 1'b1;
            sdr_addr       = {5'd0, word_addr};
        end else if (in_bank) begin
            region.banked = 1'b1;
            if (board_cfg.bank_enable) begin
                sdr_addr = `M92_BANK_BASE + {5'd0, bank_select, word_addr[15:0]};
            end else begin
                sdr_addr = {5'd0, word_addr};  // Plain ROM on unbanked boards
            end
        end else if (in_ram) begin
            region.ram_rom = 1'b1;
            sdr_addr       = `M92_RAM_BASE + {9'd0, ram_off};
            writable       = 1'b1;
        end else if (word_addr == `M92_VIDCTRL_ADDR) begin
            region.vid_ctrl = 1'b1;
        end else begin
            region.none = 1'b1;                // Open bus
        end
    end

endmodule

`default_nettype wire

//--- src/m92_io_regs.sv
// CPU I/O port registers
`timescale 1ns/1ps
`default_nettype none
`include "m92_defines.svh"

module m92_io_regs (
    input  wire logic        CLK_32M,
    input  wire logic        reset_n,
    input  wire logic [7:0]  io_addr,
    input  wire logic        io_wr,
    input  wire logic        io_rd,
    input  wire logic [7:0]  io_dout,
    input  wire logic [15:0] switches,
    input  wire logic [1:0]  coin,
    input  wire logic [1:0]  start_buttons,
    input  wire logic [23:0] dip_sw,
    input  wire logic        dbg_io_write,
    input  wire logic [7:0]  dbg_io_data,
    input  wire logic        vid_wr,
    input  wire logic [15:0] vid_data,
    output logic [7:0]       io_din,
    output logic [3:0]       bank_select,
    output logic [7:0]       sys_flags,
    output logic [15:0]      vid_ctrl,
    output logic             dbg_io_wait
);

    logic [7:0]  dbg_io_latch;
    logic [15:0] flags_word;
    logic [15:0] io16;

    assign flags_word = {dip_sw[23:16], 1'b0, 3'b111, coin, start_buttons};

    // ==============================
    // Write side
    // ==============================
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags    <= 8'h00;
            bank_select  <= 4'd0;
            vid_ctrl     <= 16'h0000;
            dbg_io_wait  <= 1'b0;
            dbg_io_latch <= 8'hff;
        end else begin
            if (io_wr && io_addr == `M92_IO_FLAGS) sys_flags <= io_dout;
            if (io_wr && io_addr == `M92_IO_BANK) bank_select <= io_dout[3:0];
            if (vid_wr) vid_ctrl <= vid_data;

            // Mailbox from the debug host, cleared when the CPU picks it up
            if (io_rd && io_addr == `M92_IO_DBG) dbg_io_wait <= 1'b0;
            if (dbg_io_write) begin
                dbg_io_wait  <= 1'b1;
                dbg_io_latch <= dbg_io_data;
            end
        end
    end

    // ==============================
    // Read mux
    // ==============================
    always_comb begin
        case ({io_addr[7:1], 1'b0})
            `M92_IO_SW:    io16 = switches;
            `M92_IO_FLAGS: io16 = flags_word;
            `M92_IO_DIP:   io16 = dip_sw[15:0];
            `M92_IO_DBG:   io16 = {dbg_io_latch, dbg_io_latch};
            default:       io16 = 16'hffff;   // Unmapped port
        endcase
        io_din = io_addr[0] ? io16[15:8] : io16[7:0];
    end

endmodule

`default_nettype wire

//--- src/m92_mem_top.sv
// M92 memory and I/O subsystem
`timescale 1ns/1ps
`default_nettype none

module m92_mem_top import m92_pkg::*; (
    input  wire logic        CLK_32M,
    input  wire logic        reset_n,
    input  board_cfg_t       board_cfg,
    input  cpu_bus_t         cpu_bus,
    output logic [15:0]      cpu_rdata,
    output logic             ce_cpu,
    output logic             cpu_busy,
    input  wire logic [7:0]  io_addr,
    input  wire logic        io_wr,
    input  wire logic        io_rd,
    input  wire logic [7:0]  io_dout,
    output logic [7:0]       io_din,
    input  wire logic [15:0] switches,
    input  wire logic [1:0]  coin,
    input  wire logic [1:0]  start_buttons,
    input  wire logic [23:0] dip_sw,
    input  wire logic        dbg_io_write,
    input  wire logic [7:0]  dbg_io_data,
    output logic             dbg_io_wait,
    output logic [7:0]       sys_flags,
    output logic [15:0]      vid_ctrl,
    input  wire logic        sprite_req,
    input  wire logic [24:0] sprite_addr,
    output logic             sprite_rdy,
    output logic [63:0]      sprite_data,
    input  wire logic        bg_req,
    input  wire logic [24:0] bg_addr,
    output logic             bg_rdy,
    output logic [31:0]      bg_data,
    output logic             mem_req,
    output logic [24:0]      mem_addr,
    output logic [15:0]      mem_din,
    output logic [1:0]       mem_wr_sel,
    input  wire logic        mem_rdy,
    input  wire logic [63:0] mem_dout
);

    region_t     region;
    logic [24:0] sdr_addr;
    logic        writable;
    logic [3:0]  bank_select;
    logic        cpu_req;
    sdr_req_t    cpu_sdr;
    logic        cpu_rdy;
    logic [15:0] cpu_rdata_mem;
    logic        vid_wr;
    logic [15:0] vid_data;

    address_translator u_translator (
        .addr(cpu_bus.addr), .board_cfg(board_cfg), .bank_select(bank_select),
        .region(region), .sdr_addr(sdr_addr), .writable(writable)
    );

    m92_io_regs u_io_regs (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .io_addr(io_addr), .io_wr(io_wr), .io_rd(io_rd), .io_dout(io_dout),
        .switches(switches), .coin(coin), .start_buttons(start_buttons), .dip_sw(dip_sw),
        .dbg_io_write(dbg_io_write), .dbg_io_data(dbg_io_data),
        .vid_wr(vid_wr), .vid_data(vid_data),
        .io_din(io_din), .bank_select(bank_select), .sys_flags(sys_flags),
        .vid_ctrl(vid_ctrl), .dbg_io_wait(dbg_io_wait)
    );

    m92_cpu_bridge u_bridge (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .cpu_bus(cpu_bus), .region(region), .sdr_addr(sdr_addr), .writable(writable),
        .cpu_rdy(cpu_rdy), .cpu_rdata_mem(cpu_rdata_mem), .vid_ctrl(vid_ctrl),
        .cpu_req(cpu_req), .cpu_sdr(cpu_sdr), .cpu_rdata(cpu_rdata), .cpu_busy(cpu_busy),
        .ce_cpu(ce_cpu), .vid_wr(vid_wr), .vid_data(vid_data)
    );

    // Sprite fetch wins over BG, CPU is served last
    sdr_arbiter u_arbiter (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .cpu_req(cpu_req), .cpu_sdr(cpu_sdr),
        .sprite_req(sprite_req), .sprite_addr(sprite_addr),
        .bg_req(bg_req), .bg_addr(bg_addr),
        .mem_rdy(mem_rdy), .mem_dout(mem_dout),
        .cpu_rdy(cpu_rdy), .cpu_rdata_mem(cpu_rdata_mem),
        .sprite_rdy(sprite_rdy), .sprite_data(sprite_data),
        .bg_rdy(bg_rdy), .bg_data(bg_data),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_din(mem_din), .mem_wr_sel(mem_wr_sel)
    );

endmodule

`default_nettype wire

//--- tests/m92_mem_sva.sv
// Arbiter and bridge assertions
`timescale 1ns/1ps
`default_nettype none

module m92_mem_sva (
    input wire logic CLK_32M,
    input wire logic reset_n,
    input wire logic arb_busy,
    input wire logic mem_req,
    input wire logic cpu_busy,
    input wire logic cpu_rdy,
    input wire logic ce_cpu
);

    int fail_count = 0;     // Failed assertions in this instance

    // ==============================
    // SDRAM port
    // ==============================
    // One access at a time
    a_no_req_when_busy: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        arb_busy |-> !mem_req)
        else begin
            $error("mem_req pulsed while the arbiter was busy");
            fail_count++;
        end

    // ==============================
    // CPU bridge
    // ==============================
    a_no_ce_when_busy: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        cpu_busy |-> !ce_cpu)
        else begin
            $error("ce_cpu pulsed while cpu_busy was high");
            fail_count++;
        end

    // Stall ends right after the answer
    a_busy_falls: assert property (@(posedge CLK_32M) disable iff (!reset_n)
        cpu_busy && cpu_rdy |=> !cpu_busy)
        else begin
            $error("cpu_busy still high after cpu_rdy");
            fail_count++;
        end

endmodule

bind sdr_arbiter m92_mem_sva arb_checks (
    .CLK_32M(CLK_32M), .reset_n(reset_n), .arb_busy(busy), .mem_req(mem_req),
    .cpu_busy(1'b0), .cpu_rdy(1'b0), .ce_cpu(1'b0)
);

bind m92_cpu_bridge m92_mem_sva bridge_checks (
    .CLK_32M(CLK_32M), .reset_n(reset_n), .arb_busy(1'b0), .mem_req(1'b0),
    .cpu_busy(cpu_busy), .cpu_rdy(cpu_rdy), .ce_cpu(ce_cpu)
);

`default_nettype wire

//--- tests/tb_m92_mem.sv
// M92 memory subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "m92_defines.svh"

module tb_m92_mem import m92_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic        CLK_32M;
    logic        reset_n = 1'b0;
    board_cfg_t  board_cfg = '{bank_enable: 1'b1, ram_wide: 1'b1};
    cpu_bus_t    cpu_bus = '0;
    logic [15:0] cpu_rdata;
    logic        ce_cpu;
    logic        cpu_busy;
    logic [7:0]  io_addr = 8'h00;
    logic        io_wr = 1'b0;
    logic        io_rd = 1'b0;
    logic [7:0]  io_dout = 8'h00;
    logic [7:0]  io_din;
    logic [15:0] switches = 16'ha55a;
    logic [1:0]  coin = 2'b10;
    logic [1:0]  start_buttons = 2'b01;
    logic [23:0] dip_sw = 24'hc37e91;
    logic        dbg_io_write = 1'b0;
    logic [7:0]  dbg_io_data = 8'h00;
    logic        dbg_io_wait;
    logic [7:0]  sys_flags;
    logic [15:0] vid_ctrl;
    logic        sprite_req = 1'b0;
    logic [24:0] sprite_addr = '0;
    logic        sprite_rdy;
    logic [63:0] sprite_data;
    logic        bg_req = 1'b0;
    logic [24:0] bg_addr = '0;
    logic        bg_rdy;
    logic [31:0] bg_data;
    logic        mem_req;
    logic [24:0] mem_addr;
    logic [15:0] mem_din;
    logic [1:0]  mem_wr_sel;
    logic        mem_rdy = 1'b0;
    logic [63:0] mem_dout = '0;

    // SDRAM model state
    logic [15:0] written [logic [24:0]];
    logic [24:0] gnt_addr_q [$];
    logic [15:0] gnt_din_q [$];
    logic [1:0]  gnt_sel_q [$];
    logic [31:0] lcg_state = 32'd81830;
    logic [3:0]  delay_left = 4'd0;
    logic [24:0] cur_addr;
    logic [15:0] cur_din;
    logic [1:0]  cur_sel;
    logic [15:0] old_word;
    logic [63:0] fill_word;
    logic [3:0]  bank_shadow = 4'd0;
    int          sprite_rdy_cnt = 0;
    int          bg_rdy_cnt = 0;
    int          err_count = 0;
    int          check_count = 0;

    m92_mem_top DUT (.*);

    initial begin
        CLK_32M = 1'b0;
        forever #5 CLK_32M = ~CLK_32M;
    end

    // ==============================
    // SDRAM model
    // ==============================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Every lane depends on the whole word address
    function automatic logic [63:0] fill64(input logic [24:0] a);
        logic [15:0] h;
        h = a[15:0] ^ {7'd0, a[24:16]};
        return {4{h}} ^ 64'h0123_4567_89ab_cdef;
    endfunction

    function automatic logic [15:0] model_word(input logic [24:0] a);
        logic [63:0] f;
        f = fill64(a);
        if (written.exists(a)) return written[a];
        return f[15:0];
    endfunction

    always @(posedge CLK_32M) begin
        mem_rdy <= 1'b0;
        if (mem_req) begin
            gnt_addr_q.push_back(mem_addr);
            gnt_din_q.push_back(mem_din);
            gnt_sel_q.push_back(mem_wr_sel);
            cur_addr   = mem_addr;
            cur_din    = mem_din;
            cur_sel    = mem_wr_sel;
            lcg_state  = lcg_next(lcg_state);
            delay_left = 4'd2 + {1'b0, lcg_state[18:16]};   // 2 to 9 cycles
        end else if (delay_left != 4'd0) begin
            delay_left = delay_left - 4'd1;
            if (delay_left == 4'd0) begin
                old_word = model_word(cur_addr);
                if (cur_sel != 2'b00) begin
                    written[cur_addr] = {cur_sel[1] ? cur_din[15:8] : old_word[15:8],
                                         cur_sel[0] ? cur_din[7:0] : old_word[7:0]};
                end
                fill_word = fill64(cur_addr);
                mem_dout <= {fill_word[63:16], model_word(cur_addr)};
                mem_rdy  <= 1'b1;
            end
        end
    end

    always @(posedge CLK_32M) begin
        if (sprite_rdy) sprite_rdy_cnt++;
        if (bg_rdy) bg_rdy_cnt++;
    end

    // ==============================
    // Checks and bus tasks
    // ==============================
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("Failure: %s", what);
    endtask

    // SDRAM address the memory map calls for
    function automatic logic [24:0] expect_sdr_addr(input logic [19:0] a);
        logic [24:0] word;
        word = {5'd0, a[19:1], 1'b0};
        if (a <= `M92_ROM_END) return word;
        if (a >= `M92_BANK_WIN_LO && a <= `M92_BANK_WIN_HI) begin
            if (!board_cfg.bank_enable) return word;
            return `M92_BANK_BASE + 25'(bank_shadow) * 25'h10000 + 25'(word[15:0]);
        end
        return `M92_RAM_BASE + 25'(board_cfg.ram_wide ? word[15:0] : {2'b00, word[13:0]});
    endfunction

    task automatic cpu_access(input logic [19:0] addr, input logic wr, input logic [15:0] data,
                              input logic [1:0] be);
        int waited;
        waited = 0;
        @(posedge CLK_32M);
        cpu_bus <= '{addr: addr, dout: data, be: be, rd: ~wr, wr: wr};
        @(posedge CLK_32M);
        cpu_bus.rd <= 1'b0;
        cpu_bus.wr <= 1'b0;
        @(negedge CLK_32M);
        while (cpu_busy && waited < TIMEOUT) begin
            @(negedge CLK_32M);
            waited++;
        end
        if (cpu_busy) report_failure("CPU access never completed");
    endtask

    task automatic check_request(input logic [24:0] addr, input logic [15:0] din,
                                 input logic [1:0] sel);
        logic [15:0] din_got;
        if (gnt_addr_q.size() == 0) begin
            report_failure("no SDRAM request seen for a CPU access");
        end else begin
            check_value("mem_addr", gnt_addr_q.pop_front(), addr);
            check_value("mem_wr_sel", gnt_sel_q.pop_front(), sel);
            din_got = gnt_din_q.pop_front();
            if (sel != 2'b00) check_value("mem_din", din_got, din);
        end
    endtask

    task automatic cpu_read_check(input logic [19:0] addr);
        logic [24:0] exp_addr;
        logic [15:0] word;
        cpu_access(addr, 1'b0, 16'h0000, 2'b11);
        exp_addr = expect_sdr_addr(addr);
        word     = model_word(exp_addr);
        check_request(exp_addr, 16'h0000, 2'b00);
        check_value("cpu_rdata", cpu_rdata, addr[0] ? {8'h00, word[15:8]} : word);
    endtask

    task automatic cpu_write_check(input logic [19:0] addr, input logic [15:0] data,
                                   input logic [1:0] be, input logic [15:0] exp_din,
                                   input logic [1:0] exp_sel);
        cpu_access(addr, 1'b1, data, be);
        check_request(expect_sdr_addr(addr), exp_din, exp_sel);
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        @(posedge CLK_32M);
        io_addr <= port;
        io_dout <= data;
        io_wr   <= 1'b1;
        @(posedge CLK_32M);
        io_wr <= 1'b0;
        if (port == `M92_IO_BANK) bank_shadow = data[3:0];
    endtask

    task automatic io_read_check(input logic [7:0] port, input logic [7:0] exp);
        @(posedge CLK_32M);
        io_addr <= port;
        io_rd   <= 1'b1;
        @(negedge CLK_32M);
        check_value("io_din", io_din, exp);
        @(posedge CLK_32M);
        io_rd <= 1'b0;
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        int ce_pulses;
        int sprite_before;
        int bg_before;
        int waited;
        int sva_fails;

        repeat (2) @(posedge CLK_32M);
        reset_n <= 1'b1;
        @(negedge CLK_32M);
        check_value("ce_cpu", ce_cpu, 1'b0);
        check_value("cpu_busy", cpu_busy, 1'b0);
        check_value("mem_req", mem_req, 1'b0);
        check_value("sprite_rdy", sprite_rdy, 1'b0);
        check_value("bg_rdy", bg_rdy, 1'b0);
        check_value("dbg_io_wait", dbg_io_wait, 1'b0);
        check_value("vid_ctrl", vid_ctrl, 16'h0000);

        // Idle CPU runs at a quarter of the clock
        ce_pulses = 0;
        repeat (16) begin
            @(negedge CLK_32M);
            if (ce_cpu) ce_pulses++;
        end
        check_value("ce_cpu pulse count", ce_pulses, 4);

        // Input ports and debug mailbox
        io_read_check(`M92_IO_DBG, 8'hff);
        io_read_check(`M92_IO_SW, switches[7:0]);
        io_read_check(`M92_IO_SW + 8'd1, switches[15:8]);
        io_read_check(`M92_IO_FLAGS, 8'h79);       // Spare 0, three ones, coin 10, start 01
        io_read_check(`M92_IO_FLAGS + 8'd1, dip_sw[23:16]);
        io_read_check(`M92_IO_DIP, dip_sw[7:0]);
        io_read_check(`M92_IO_DIP + 8'd1, dip_sw[15:8]);
        io_write(`M92_IO_FLAGS, 8'h5c);
        @(negedge CLK_32M);
        check_value("sys_flags", sys_flags, 8'h5c);
        @(posedge CLK_32M);
        dbg_io_write <= 1'b1;
        dbg_io_data  <= 8'h3c;
        @(posedge CLK_32M);
        dbg_io_write <= 1'b0;
        @(negedge CLK_32M);
        check_value("dbg_io_wait", dbg_io_wait, 1'b1);
        io_read_check(`M92_IO_DBG, 8'h3c);
        @(negedge CLK_32M);
        check_value("dbg_io_wait", dbg_io_wait, 1'b0);

        // ROM, banked window and work RAM translation
        cpu_read_check(20'h12345);
        cpu_read_check(20'hbfffe);
        cpu_read_check(20'hc0010);
        io_write(`M92_IO_BANK, 8'h03);
        cpu_read_check(20'hc1235);
        io_write(`M92_IO_BANK, 8'h0a);
        cpu_read_check(20'hcfffe);
        @(posedge CLK_32M);
        board_cfg <= '{bank_enable: 1'b0, ram_wide: 1'b1};
        cpu_read_check(20'hc1234);
        cpu_read_check(20'he4010);
        @(posedge CLK_32M);
        board_cfg <= '{bank_enable: 1'b1, ram_wide: 1'b0};
        cpu_read_check(20'he4010);
        @(posedge CLK_32M);
        board_cfg <= '{bank_enable: 1'b1, ram_wide: 1'b1};

        // Byte lanes on writes and read back
        cpu_write_check(20'he0010, 16'hbeef, 2'b11, 16'hbeef, 2'b11);
        cpu_read_check(20'he0010);
        check_value("cpu_rdata", cpu_rdata, 16'hbeef);
        cpu_write_check(20'he0021, 16'h005a, 2'b01, 16'h5a00, 2'b10);
        cpu_read_check(20'he0021);
        check_value("cpu_rdata", cpu_rdata, 16'h005a);
        cpu_write_check(20'h00100, 16'h1111, 2'b11, 16'h0000, 2'b00);
        cpu_read_check(20'h00100);

        // Video control register and open bus
        cpu_access(`M92_VIDCTRL_ADDR, 1'b1, 16'h1234, 2'b11);
        check_value("vid_ctrl", vid_ctrl, 16'h1234);
        cpu_access(`M92_VIDCTRL_ADDR, 1'b0, 16'h0000, 2'b11);
        check_value("cpu_rdata", cpu_rdata, 16'h1234);
        cpu_access(20'hf0000, 1'b0, 16'h0000, 2'b11);
        check_value("cpu_rdata", cpu_rdata, 16'hffff);
        check_value("gnt_addr_q.size", gnt_addr_q.size(), 0);

        // Three peers at once
        sprite_before = sprite_rdy_cnt;
        bg_before     = bg_rdy_cnt;
        @(posedge CLK_32M);
        cpu_bus <= '{addr: 20'h12346, dout: 16'h0000, be: 2'b11, rd: 1'b1, wr: 1'b0};
        @(posedge CLK_32M);
        cpu_bus.rd  <= 1'b0;
        sprite_req  <= 1'b1;
        sprite_addr <= 25'h0123400;
        bg_req      <= 1'b1;
        bg_addr     <= 25'h0345600;
        @(posedge CLK_32M);
        sprite_req <= 1'b0;
        bg_req     <= 1'b0;
        waited = 0;
        @(negedge CLK_32M);
        while ((cpu_busy || sprite_rdy_cnt == sprite_before || bg_rdy_cnt == bg_before)
               && waited < TIMEOUT) begin
            @(negedge CLK_32M);
            waited++;
        end
        if (waited >= TIMEOUT) report_failure("concurrent requests never completed");
        if (gnt_addr_q.size() != 3) begin
            report_failure("expected three SDRAM grants for three peers");
        end else begin
            check_value("mem_addr (1st grant)", gnt_addr_q.pop_front(), 25'h0123400);
            check_value("mem_addr (2nd grant)", gnt_addr_q.pop_front(), 25'h0345600);
            check_value("mem_addr (3rd grant)", gnt_addr_q.pop_front(), 25'h0012346);
        end
        fill_word = fill64(25'h0345600);
        check_value("sprite_data", sprite_data, fill64(25'h0123400));
        check_value("bg_data", bg_data, fill_word[31:0]);
        check_value("cpu_rdata", cpu_rdata, model_word(25'h0012346));
        check_value("sprite_rdy pulses", sprite_rdy_cnt - sprite_before, 1);
        check_value("bg_rdy pulses", bg_rdy_cnt - bg_before, 1);

        sva_fails = DUT.u_arbiter.arb_checks.fail_count
                  + DUT.u_bridge.bridge_checks.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, err_count, sva_fails);
        if (err_count == 0 && sva_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
